// ==== cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

    // data word and its byte strobes
    localparam int word_width = 64;
    localparam int strb_width = word_width / 8;

    // default geometry, the top level may override it
    localparam int def_addr_width  = 32;
    localparam int def_line_count  = 64;
    localparam int def_block_words = 4;

endpackage

`default_nettype wire

// ==== mem_op_pkg.sv ====
`default_nettype none

package mem_op_pkg;

    typedef enum logic [1:0] {
        ctrl_none  = 2'd0,
        ctrl_load  = 2'd1,
        ctrl_store = 2'd2   // atomics travel as stores with a non-idle opcode
    } ctrl_e;

    typedef enum logic [3:0] {
        amo_idle = 4'd0,
        amo_swap = 4'd1,
        amo_add  = 4'd2,
        amo_xor  = 4'd3,
        amo_and  = 4'd4,
        amo_or   = 4'd5,
        amo_min  = 4'd6,
        amo_max  = 4'd7,
        amo_minu = 4'd8,
        amo_maxu = 4'd9
    } amo_e;

    // one word, seen whole or as the two halves that a 32-bit atomic works on
    typedef union packed {
        logic [cache_geom_pkg::word_width-1:0] word;
        struct packed {
            logic [31:0] hi;
            logic [31:0] lo;
        } half;
    } amo_word_u;

endpackage

`default_nettype wire

// ==== dcache_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_ram #(
    parameter int ram_width  = 64,
    parameter int line_count = cache_geom_pkg::def_line_count,
    localparam int index_width = $clog2(line_count)
) (
    input  wire                   CLK,
    input  wire                   wren,
    input  wire [index_width-1:0] waddr,
    input  wire [index_width-1:0] raddr,
    input  wire [ram_width-1:0]   wdata,
    output logic [ram_width-1:0]  rdata
);

    logic [ram_width-1:0] mem [line_count];

    always_ff @(posedge CLK) begin
        if (wren) begin
            mem[waddr] <= wdata;
        end
        // a read of the line being written sees the new contents
        rdata <= (wren && waddr == raddr) ? wdata : mem[raddr];
    end

endmodule

`default_nettype wire

// ==== dcache_flag_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_flag_ram #(
    parameter int line_count = cache_geom_pkg::def_line_count,
    localparam int index_width = $clog2(line_count)
) (
    input  wire                   CLK,
    input  wire                   RST,
    input  wire                   wren,
    input  wire [index_width-1:0] waddr,
    input  wire                   wbit,
    input  wire [index_width-1:0] raddr,
    output logic                  rbit
);

    logic [line_count-1:0] bits;

    always_ff @(posedge CLK) begin
        if (RST) begin
            bits <= '0;     // cold cache is all invalid and clean
            rbit <= 1'b0;
        end else begin
            if (wren) begin
                bits[waddr] <= wbit;
            end
            rbit <= (wren && waddr == raddr) ? wbit : bits[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== dcache_amo_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_amo_unit (
    input  wire [cache_geom_pkg::word_width-1:0]  old_word,
    input  wire [cache_geom_pkg::word_width-1:0]  store_word,
    input  wire [cache_geom_pkg::strb_width-1:0]  strb,
    input  wire mem_op_pkg::amo_e                 amo,
    input  wire                                   op32,
    input  wire                                   half_sel,
    output logic [cache_geom_pkg::word_width-1:0] new_word
);
    import cache_geom_pkg::*;
    import mem_op_pkg::*;

    amo_word_u             old_u;
    amo_word_u             st_u;
    amo_word_u             res_u;
    logic [31:0]           old_half;
    logic [31:0]           st_half;
    logic                  sext;
    logic [word_width-1:0] opa;
    logic [word_width-1:0] opb;
    logic [word_width-1:0] op_res;

    assign old_u = old_word;
    assign st_u  = store_word;

    assign old_half = half_sel ? old_u.half.hi : old_u.half.lo;
    assign st_half  = half_sel ? st_u.half.hi : st_u.half.lo;

    // a 32-bit operand is widened so that one 64-bit datapath serves both sizes
    assign sext = (amo == amo_min) || (amo == amo_max);
    assign opa  = op32 ? {{32{sext & old_half[31]}}, old_half} : old_u.word;
    assign opb  = op32 ? {{32{sext & st_half[31]}}, st_half} : st_u.word;

    always_comb begin
        case (amo)
            amo_swap: op_res = opb;
            amo_add:  op_res = opa + opb;
            amo_xor:  op_res = opa ^ opb;
            amo_and:  op_res = opa & opb;
            amo_or:   op_res = opa | opb;
            amo_min:  op_res = ($signed(opa) < $signed(opb)) ? opa : opb;
            amo_max:  op_res = ($signed(opa) > $signed(opb)) ? opa : opb;
            amo_minu: op_res = (opa < opb) ? opa : opb;
            amo_maxu: op_res = (opa > opb) ? opa : opb;
            default:  op_res = opa;
        endcase
    end

    always_comb begin
        res_u = old_u;
        if (amo == amo_idle) begin
            for (int i = 0; i < strb_width; i++) begin
                if (strb[i]) begin
                    res_u.word[i*8 +: 8] = st_u.word[i*8 +: 8];
                end
            end
        end else if (!op32) begin
            res_u.word = op_res;
        end else if (half_sel) begin
            res_u.half.hi = op_res[31:0];   // other half keeps its stored value
        end else begin
            res_u.half.lo = op_res[31:0];
        end
    end

    assign new_word = res_u.word;

endmodule

`default_nettype wire

// ==== dcache_req_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_req_pipe #(
    parameter int addr_width = cache_geom_pkg::def_addr_width
) (
    input  wire                                   CLK,
    input  wire                                   RST,
    input  wire                                   ADDR_VALID,
    input  wire [addr_width-1:0]                  ADDR,
    input  wire mem_op_pkg::ctrl_e                CONTROL,
    input  wire [cache_geom_pkg::word_width-1:0]  DATA_in,
    input  wire [cache_geom_pkg::strb_width-1:0]  WSTRB,
    input  wire mem_op_pkg::amo_e                 AMO,
    input  wire                                   OP32,
    input  wire                                   stall,
    output logic [addr_width-1:0]                 s1_addr,
    output logic [addr_width-1:0]                 s2_addr,
    output mem_op_pkg::ctrl_e                     s2_kind,
    output logic [cache_geom_pkg::word_width-1:0] s2_data,
    output logic [cache_geom_pkg::strb_width-1:0] s2_strb,
    output mem_op_pkg::amo_e                      s2_amo,
    output logic                                  s2_op32
);
    import cache_geom_pkg::*;
    import mem_op_pkg::*;

    ctrl_e                 s1_kind;
    logic [word_width-1:0] s1_data;
    logic [strb_width-1:0] s1_strb;
    amo_e                  s1_amo;
    logic                  s1_op32;

    always_ff @(posedge CLK) begin
        if (RST) begin
            s1_kind <= ctrl_none;
            s2_kind <= ctrl_none;
        end else if (!stall) begin
            s1_kind <= ADDR_VALID ? CONTROL : ctrl_none;   // idle cycles enter as bubbles
            s2_kind <= s1_kind;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            s1_addr <= ADDR;
            s1_data <= DATA_in;
            s1_strb <= WSTRB;
            s1_amo  <= AMO;
            s1_op32 <= OP32;
            s2_addr <= s1_addr;
            s2_data <= s1_data;
            s2_strb <= s1_strb;
            s2_amo  <= s1_amo;
            s2_op32 <= s1_op32;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl #(
    parameter int addr_width  = cache_geom_pkg::def_addr_width,
    parameter int line_count  = cache_geom_pkg::def_line_count,
    parameter int block_words = cache_geom_pkg::def_block_words,
    localparam int index_width  = $clog2(line_count),
    localparam int woff_width   = $clog2(block_words),
    localparam int offset_width = woff_width + $clog2(cache_geom_pkg::strb_width),
    localparam int tag_width    = addr_width - index_width - offset_width,
    localparam int line_width   = block_words * cache_geom_pkg::word_width
) (
    input  wire                                   CLK,
    input  wire                                   RST,
    input  wire [addr_width-1:0]                  s1_addr,
    input  wire [addr_width-1:0]                  s2_addr,
    input  wire mem_op_pkg::ctrl_e                s2_kind,
    input  wire [tag_width-1:0]                   tag_rdata,
    input  wire                                   valid_rdata,
    input  wire                                   dirty_rdata,
    input  wire [line_width-1:0]                  line_rdata,
    input  wire [cache_geom_pkg::word_width-1:0]  new_word,
    input  wire                                   DATA_FROM_L2_VALID,
    input  wire [line_width-1:0]                  DATA_FROM_L2,
    input  wire                                   WRITE_DONE,
    output logic                                  stall,
    output logic                                  CACHE_READY,
    output logic [cache_geom_pkg::word_width-1:0] DATA,
    output logic [cache_geom_pkg::word_width-1:0] old_word,
    output logic                                  half_sel,
    output logic [index_width-1:0]                rd_index,
    output logic [index_width-1:0]                wr_index,
    output logic                                  data_wren,
    output logic [line_width-1:0]                 data_wdata,
    output logic                                  tag_wren,
    output logic [tag_width-1:0]                  tag_wdata,
    output logic                                  valid_wren,
    output logic                                  valid_wbit,
    output logic                                  dirty_wren,
    output logic                                  dirty_wbit,
    output logic                                  ADDR_TO_L2_VALID,
    output logic [addr_width-offset_width-1:0]    ADDR_TO_L2,
    output logic                                  DATA_TO_L2_VALID,
    output logic [addr_width-offset_width-1:0]    WADDR_TO_L2,
    output logic [line_width-1:0]                 DATA_TO_L2
);
    import cache_geom_pkg::*;
    import mem_op_pkg::*;

    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_wb        = 3'd1;
    localparam logic [2:0] st_wait_wr   = 3'd2;
    localparam logic [2:0] st_fetch     = 3'd3;
    localparam logic [2:0] st_wait_fill = 3'd4;
    localparam logic [2:0] st_replay    = 3'd5;

    logic [2:0]             state;
    logic [2:0]             state_nxt;
    logic [index_width-1:0] s2_index;
    logic [tag_width-1:0]   s2_tag;
    logic [woff_width-1:0]  s2_woff;
    logic                   s2_active;
    logic                   hit;
    logic                   miss;
    logic                   run;
    logic                   hit_wr;
    logic                   fill;
    logic [line_width-1:0]  merged_line;

    assign s2_index = s2_addr[offset_width +: index_width];
    assign s2_tag   = s2_addr[addr_width-1 -: tag_width];
    assign s2_woff  = s2_addr[offset_width-1 -: woff_width];

    // ########################################################################
    // compare stage

    assign s2_active   = s2_kind != ctrl_none;
    assign hit         = valid_rdata && tag_rdata == s2_tag;
    assign miss        = s2_active && !hit;
    assign run         = state == st_idle || state == st_replay;
    assign CACHE_READY = run && !miss;
    assign stall       = !CACHE_READY;

    assign old_word = line_rdata[s2_woff*word_width +: word_width];
    assign DATA     = old_word;       // loads and atomics both return the stored word
    assign half_sel = s2_addr[2];

    always_comb begin
        merged_line = line_rdata;
        merged_line[s2_woff*word_width +: word_width] = new_word;
    end

    // while frozen the arrays keep reading the missed line, so replay sees the refill
    assign rd_index = stall ? s2_index : s1_addr[offset_width +: index_width];
    assign wr_index = s2_index;

    assign hit_wr = CACHE_READY && s2_kind == ctrl_store;
    assign fill   = state == st_wait_fill && DATA_FROM_L2_VALID;

    assign data_wren  = hit_wr || fill;
    assign data_wdata = fill ? DATA_FROM_L2 : merged_line;
    assign tag_wren   = fill;
    assign tag_wdata  = s2_tag;
    assign valid_wren = fill;
    assign valid_wbit = 1'b1;
    assign dirty_wren = hit_wr || fill;
    assign dirty_wbit = hit_wr;       // a refilled line starts clean

    // ########################################################################
    // miss sequencer

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle, st_replay: begin
                if (miss) begin
                    state_nxt = (valid_rdata && dirty_rdata) ? st_wb : st_fetch;
                end else begin
                    state_nxt = st_idle;
                end
            end
            st_wb:        state_nxt = st_wait_wr;
            st_wait_wr:   state_nxt = WRITE_DONE ? st_fetch : st_wait_wr;
            st_fetch:     state_nxt = st_wait_fill;
            st_wait_fill: state_nxt = DATA_FROM_L2_VALID ? st_replay : st_wait_fill;
            default:      state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // each request pulse lasts exactly the one cycle spent in its state
    assign DATA_TO_L2_VALID = state == st_wb;
    assign WADDR_TO_L2      = {tag_rdata, s2_index};
    assign DATA_TO_L2       = line_rdata;
    assign ADDR_TO_L2_VALID = state == st_fetch;
    assign ADDR_TO_L2       = s2_addr[addr_width-1:offset_width];

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_top #(
    parameter int addr_width  = cache_geom_pkg::def_addr_width,
    parameter int line_count  = cache_geom_pkg::def_line_count,
    parameter int block_words = cache_geom_pkg::def_block_words,
    localparam int index_width  = $clog2(line_count),
    localparam int offset_width = $clog2(block_words) + $clog2(cache_geom_pkg::strb_width),
    localparam int tag_width    = addr_width - index_width - offset_width,
    localparam int line_width   = block_words * cache_geom_pkg::word_width
) (
    input  wire                                   CLK,
    input  wire                                   RST,
    input  wire                                   ADDR_VALID,
    input  wire [addr_width-1:0]                  ADDR,
    input  wire mem_op_pkg::ctrl_e                CONTROL,
    input  wire [cache_geom_pkg::word_width-1:0]  DATA_in,
    input  wire [cache_geom_pkg::strb_width-1:0]  WSTRB,
    input  wire mem_op_pkg::amo_e                 AMO,
    input  wire                                   OP32,
    output logic [cache_geom_pkg::word_width-1:0] DATA,
    output logic                                  CACHE_READY,
    output logic                                  ADDR_TO_L2_VALID,
    output logic [addr_width-offset_width-1:0]    ADDR_TO_L2,
    output logic                                  DATA_TO_L2_VALID,
    output logic [addr_width-offset_width-1:0]    WADDR_TO_L2,
    output logic [line_width-1:0]                 DATA_TO_L2,
    input  wire                                   DATA_FROM_L2_VALID,
    input  wire [line_width-1:0]                  DATA_FROM_L2,
    input  wire                                   WRITE_DONE
);
    import cache_geom_pkg::*;
    import mem_op_pkg::*;

    logic                   stall;
    logic [addr_width-1:0]  s1_addr;
    logic [addr_width-1:0]  s2_addr;
    ctrl_e                  s2_kind;
    logic [word_width-1:0]  s2_data;
    logic [strb_width-1:0]  s2_strb;
    amo_e                   s2_amo;
    logic                   s2_op32;
    logic [word_width-1:0]  old_word;
    logic [word_width-1:0]  new_word;
    logic                   half_sel;
    logic [index_width-1:0] rd_index;
    logic [index_width-1:0] wr_index;
    logic                   data_wren;
    logic [line_width-1:0]  data_wdata;
    logic [line_width-1:0]  line_rdata;
    logic                   tag_wren;
    logic [tag_width-1:0]   tag_wdata;
    logic [tag_width-1:0]   tag_rdata;
    logic                   valid_wren;
    logic                   valid_wbit;
    logic                   valid_rdata;
    logic                   dirty_wren;
    logic                   dirty_wbit;
    logic                   dirty_rdata;

    dcache_req_pipe #(.addr_width(addr_width)) i_req_pipe (
        .CLK(CLK), .RST(RST), .ADDR_VALID(ADDR_VALID), .ADDR(ADDR), .CONTROL(CONTROL),
        .DATA_in(DATA_in), .WSTRB(WSTRB), .AMO(AMO), .OP32(OP32), .stall(stall),
        .s1_addr(s1_addr), .s2_addr(s2_addr), .s2_kind(s2_kind), .s2_data(s2_data),
        .s2_strb(s2_strb), .s2_amo(s2_amo), .s2_op32(s2_op32)
    );

    dcache_ctrl #(
        .addr_width(addr_width), .line_count(line_count), .block_words(block_words)
    ) i_ctrl (
        .CLK(CLK), .RST(RST), .s1_addr(s1_addr), .s2_addr(s2_addr), .s2_kind(s2_kind),
        .tag_rdata(tag_rdata), .valid_rdata(valid_rdata), .dirty_rdata(dirty_rdata),
        .line_rdata(line_rdata), .new_word(new_word),
        .DATA_FROM_L2_VALID(DATA_FROM_L2_VALID), .DATA_FROM_L2(DATA_FROM_L2),
        .WRITE_DONE(WRITE_DONE), .stall(stall), .CACHE_READY(CACHE_READY), .DATA(DATA),
        .old_word(old_word), .half_sel(half_sel), .rd_index(rd_index), .wr_index(wr_index),
        .data_wren(data_wren), .data_wdata(data_wdata), .tag_wren(tag_wren),
        .tag_wdata(tag_wdata), .valid_wren(valid_wren), .valid_wbit(valid_wbit),
        .dirty_wren(dirty_wren), .dirty_wbit(dirty_wbit),
        .ADDR_TO_L2_VALID(ADDR_TO_L2_VALID), .ADDR_TO_L2(ADDR_TO_L2),
        .DATA_TO_L2_VALID(DATA_TO_L2_VALID), .WADDR_TO_L2(WADDR_TO_L2),
        .DATA_TO_L2(DATA_TO_L2)
    );

    dcache_amo_unit i_amo_unit (
        .old_word(old_word), .store_word(s2_data), .strb(s2_strb), .amo(s2_amo),
        .op32(s2_op32), .half_sel(half_sel), .new_word(new_word)
    );

    // ########################################################################
    // line storage, all four arrays share the read and write index

    dcache_ram #(.ram_width(line_width), .line_count(line_count)) i_data_ram (
        .CLK(CLK), .wren(data_wren), .waddr(wr_index), .raddr(rd_index),
        .wdata(data_wdata), .rdata(line_rdata)
    );

    dcache_ram #(.ram_width(tag_width), .line_count(line_count)) i_tag_ram (
        .CLK(CLK), .wren(tag_wren), .waddr(wr_index), .raddr(rd_index),
        .wdata(tag_wdata), .rdata(tag_rdata)
    );

    dcache_flag_ram #(.line_count(line_count)) i_valid_ram (
        .CLK(CLK), .RST(RST), .wren(valid_wren), .waddr(wr_index), .wbit(valid_wbit),
        .raddr(rd_index), .rbit(valid_rdata)
    );

    dcache_flag_ram #(.line_count(line_count)) i_dirty_ram (
        .CLK(CLK), .RST(RST), .wren(dirty_wren), .waddr(wr_index), .wbit(dirty_wbit),
        .raddr(rd_index), .rbit(dirty_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int half_period  = 4,
    parameter int reset_cycles = 2
) (
    output logic CLK,
    output logic RST
);

    initial begin
        CLK = 1'b0;
        forever #(half_period) CLK = ~CLK;
    end

    initial begin
        RST = 1'b1;
        repeat (reset_cycles) @(posedge CLK);
        #1 RST = 1'b0;     // released just after an edge, like every other input
    end

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
    import cache_geom_pkg::*;
    import mem_op_pkg::*;

    localparam int addr_width   = 32;
    localparam int line_count   = 8;
    localparam int block_words  = 4;
    localparam int line_width   = block_words * word_width;
    localparam int laddr_width  = addr_width - $clog2(block_words) - $clog2(strb_width);
    localparam int mem_words    = 1024;    // 8 KB of modelled L2, word addressed
    localparam int timeout_max  = 200;

    typedef logic [line_width-1:0]  line_t;
    typedef logic [laddr_width-1:0] laddr_t;
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [1:0]            kind;
        logic [word_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic [3:0]            amo;
        logic                  op32;
    } req_t;

    logic                  CLK;
    logic                  RST;
    logic                  ADDR_VALID;
    logic [addr_width-1:0] ADDR;
    ctrl_e                 CONTROL;
    logic [word_width-1:0] DATA_in;
    logic [strb_width-1:0] WSTRB;
    amo_e                  AMO;
    logic                  OP32;
    logic [word_width-1:0] DATA;
    logic                  CACHE_READY;
    logic                  ADDR_TO_L2_VALID;
    laddr_t                ADDR_TO_L2;
    logic                  DATA_TO_L2_VALID;
    laddr_t                WADDR_TO_L2;
    line_t                 DATA_TO_L2;
    logic                  DATA_FROM_L2_VALID;
    line_t                 DATA_FROM_L2;
    logic                  WRITE_DONE;

    logic [word_width-1:0] l2_mem [mem_words];
    logic [word_width-1:0] shadow [mem_words];   // architectural view of memory
    logic [31:0]           lfsr = 32'd95;
    string                 test_name = "none";
    int                    issued = 0;
    int                    done_count = 0;
    int                    wb_count = 0;
    int                    fetch_count = 0;
    int                    l2_seq = 0;
    int                    wb_seq = 0;
    int                    fetch_seq = 0;
    laddr_t                wb_line;
    logic                  s1_busy = 1'b0;
    logic                  s2_busy = 1'b0;
    req_t                  s1_req;
    req_t                  s2_req;

    tb_clock_gen #(.half_period(4), .reset_cycles(2)) i_clock_gen (.CLK(CLK), .RST(RST));

    dcache_top #(
        .addr_width(addr_width), .line_count(line_count), .block_words(block_words)
    ) i_dcache_top (
        .CLK(CLK), .RST(RST), .ADDR_VALID(ADDR_VALID), .ADDR(ADDR), .CONTROL(CONTROL),
        .DATA_in(DATA_in), .WSTRB(WSTRB), .AMO(AMO), .OP32(OP32), .DATA(DATA),
        .CACHE_READY(CACHE_READY), .ADDR_TO_L2_VALID(ADDR_TO_L2_VALID),
        .ADDR_TO_L2(ADDR_TO_L2), .DATA_TO_L2_VALID(DATA_TO_L2_VALID),
        .WADDR_TO_L2(WADDR_TO_L2), .DATA_TO_L2(DATA_TO_L2),
        .DATA_FROM_L2_VALID(DATA_FROM_L2_VALID), .DATA_FROM_L2(DATA_FROM_L2),
        .WRITE_DONE(WRITE_DONE)
    );

    // ########################################################################
    // random source, reference model and checks

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [63:0] op_result(logic [63:0] a, logic [63:0] b, amo_e op,
                                              logic narrow);
        logic lt_s;
        logic lt_u;
        lt_s = narrow ? ($signed(a[31:0]) < $signed(b[31:0])) : ($signed(a) < $signed(b));
        lt_u = narrow ? (a[31:0] < b[31:0]) : (a < b);
        case (op)
            amo_swap: return b;
            amo_add:  return a + b;
            amo_xor:  return a ^ b;
            amo_and:  return a & b;
            amo_or:   return a | b;
            amo_min:  return lt_s ? a : b;
            amo_max:  return lt_s ? b : a;
            amo_minu: return lt_u ? a : b;
            amo_maxu: return lt_u ? b : a;
            default:  return a;
        endcase
    endfunction

    // expected memory word after a store or atomic
    function automatic amo_word_u ref_update(amo_word_u old, amo_word_u st,
                                             logic [7:0] strb, amo_e op, logic op32,
                                             logic hsel);
        amo_word_u   res;
        logic [63:0] tmp;
        res = old;
        if (op == amo_idle) begin
            for (int i = 0; i < 8; i++) begin
                if (strb[i]) res.word[8*i +: 8] = st.word[8*i +: 8];
            end
        end else if (!op32) begin
            res.word = op_result(old.word, st.word, op, 1'b0);
        end else if (hsel) begin
            tmp = op_result({32'h0, old.half.hi}, {32'h0, st.half.hi}, op, 1'b1);
            res.half.hi = tmp[31:0];
        end else begin
            tmp = op_result({32'h0, old.half.lo}, {32'h0, st.half.lo}, op, 1'b1);
            res.half.lo = tmp[31:0];
        end
        return res;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input amo_word_u exp, input amo_word_u act);
        if (exp.word !== act.word) begin
            fail_now($sformatf("FAILED %s expected %h actual %h", name, exp.word, act.word));
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (exp !== act) begin
            fail_now($sformatf("FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_laddr(input string name, input laddr_t exp, input laddr_t act);
        if (exp !== act) begin
            fail_now($sformatf("FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic complete_request(input req_t r);
        int        idx;
        amo_word_u exp;
        amo_word_u upd;
        idx = r.addr[12:3];
        exp = shadow[idx];
        if (r.kind == ctrl_load || r.amo != amo_idle) check_word(test_name, exp, DATA);
        if (r.kind == ctrl_store) begin
            upd = ref_update(exp, r.data, r.strb, amo_e'(r.amo), r.op32, r.addr[2]);
            shadow[idx] = upd.word;
        end
        done_count++;
    endtask

    // mirror of the two request stages which move only while CACHE_READY is high
    always @(negedge CLK) begin
        if (RST === 1'b0 && CACHE_READY === 1'b1) begin
            if (s2_busy) complete_request(s2_req);
            s2_busy = s1_busy;
            s2_req  = s1_req;
            s1_busy = ADDR_VALID && CONTROL != ctrl_none;
            s1_req  = {ADDR, CONTROL, DATA_in, WSTRB, AMO, OP32};
        end
    end

    // ########################################################################
    // L2 model

    initial begin : l2_model
        int     d;
        laddr_t la;
        line_t  fill_line;
        DATA_FROM_L2_VALID = 1'b0;
        DATA_FROM_L2 = '0;
        WRITE_DONE = 1'b0;
        forever begin
            @(negedge CLK);
            if (DATA_TO_L2_VALID === 1'b1) begin
                la = WADDR_TO_L2;
                if (la >= mem_words / block_words) fail_now("write-back outside L2 memory");
                for (int w = 0; w < block_words; w++) begin
                    fill_line[w*word_width +: word_width] = shadow[la * block_words + w];
                end
                check_line(test_name, fill_line, DATA_TO_L2);
                for (int w = 0; w < block_words; w++) begin
                    l2_mem[la * block_words + w] = DATA_TO_L2[w*word_width +: word_width];
                end
                wb_line = la;
                wb_seq = l2_seq++;
                wb_count++;
                d = 1 + int'(rand_bits(2));
                repeat (d) @(posedge CLK);
                #1 WRITE_DONE = 1'b1;
                @(posedge CLK);
                #1 WRITE_DONE = 1'b0;
            end else if (ADDR_TO_L2_VALID === 1'b1) begin
                la = ADDR_TO_L2;
                if (!s2_busy) fail_now("refill requested with no request waiting");
                check_laddr(test_name, s2_req.addr[31:5], la);
                if (la >= mem_words / block_words) fail_now("refill outside L2 memory");
                fetch_seq = l2_seq++;
                fetch_count++;
                d = 1 + int'(rand_bits(2));
                repeat (d) @(posedge CLK);
                for (int w = 0; w < block_words; w++) begin
                    fill_line[w*word_width +: word_width] = l2_mem[la * block_words + w];
                end
                #1 DATA_FROM_L2 = fill_line;
                DATA_FROM_L2_VALID = 1'b1;
                @(posedge CLK);
                #1 DATA_FROM_L2_VALID = 1'b0;
            end
        end
    end

    // ########################################################################
    // stimulus

    task automatic issue(input ctrl_e kind, input logic [31:0] addr, input logic [63:0] data,
                         input logic [7:0] strb, input amo_e op, input logic op32);
        int n;
        ADDR_VALID = 1'b1;
        ADDR = addr;
        CONTROL = kind;
        DATA_in = data;
        WSTRB = strb;
        AMO = op;
        OP32 = op32;
        n = 0;
        @(negedge CLK);
        while (CACHE_READY !== 1'b1) begin
            n++;
            if (n > timeout_max) fail_now($sformatf("request to %h never accepted", addr));
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        issued++;
    endtask

    task automatic drain();
        int n;
        ADDR_VALID = 1'b0;
        CONTROL = ctrl_none;
        n = 0;
        while (done_count != issued) begin
            n++;
            if (n > timeout_max) fail_now("accepted requests did not all complete in time");
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic run_one(input ctrl_e kind, input logic [31:0] addr,
                           input logic [63:0] data, input logic [7:0] strb,
                           input amo_e op, input logic op32);
        issue(kind, addr, data, strb, op, op32);
        drain();
    endtask

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] evict_addr;
        int          n;
        int          wb_before;
        int          fetch_before;
        ADDR_VALID = 1'b0;
        ADDR = '0;
        CONTROL = ctrl_none;
        DATA_in = '0;
        WSTRB = '0;
        AMO = amo_idle;
        OP32 = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            l2_mem[i] = rand_bits(64);
            shadow[i] = l2_mem[i];
        end
        n = 0;
        @(negedge CLK);
        while (RST !== 1'b0) begin
            n++;
            if (n > 20) fail_now("reset was never released");
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;

        test_name = "reset_state";
        if (ADDR_TO_L2_VALID !== 1'b0 || DATA_TO_L2_VALID !== 1'b0) begin
            fail_now("an L2 request output is not low after reset");
        end
        if (CACHE_READY !== 1'b1) fail_now("CACHE_READY is not high after reset");
        test_name = "first_load";
        run_one(ctrl_load, 32'h0000_0128, '0, '0, amo_idle, 1'b0);
        if (fetch_count != 1) fail_now("the first load did not request a refill");

        test_name = "strobed_store";
        run_one(ctrl_store, 32'h0000_0128, rand_bits(64), 8'ha5, amo_idle, 1'b0);
        run_one(ctrl_load, 32'h0000_0128, '0, '0, amo_idle, 1'b0);

        test_name = "dirty_evict";
        evict_addr = 32'h0000_0148;
        run_one(ctrl_store, evict_addr, rand_bits(64), 8'hff, amo_idle, 1'b0);
        wb_before = wb_count;
        run_one(ctrl_load, evict_addr + 32'h100, '0, '0, amo_idle, 1'b0);
        if (wb_count != wb_before + 1) fail_now("the dirty victim line was not written back");
        check_laddr(test_name, evict_addr[31:5], wb_line);
        if (wb_seq + 1 != fetch_seq) fail_now("the write-back did not precede the refill");

        // each opcode as a 64-bit op, then on the low and on the high half
        for (int op = 1; op <= 9; op++) begin
            for (int mode = 0; mode < 3; mode++) begin
                test_name = $sformatf("amo_op%0d_mode%0d", op, mode);
                addr = 32'h0000_0600 + (op << 5) + (mode << 3) + ((mode == 2) ? 4 : 0);
                run_one(ctrl_store, addr, rand_bits(64), 8'hff, amo_e'(op), mode != 0);
                run_one(ctrl_load, addr, '0, '0, amo_idle, 1'b0);
            end
        end

        test_name = "warm_lines";
        for (int i = 0; i < line_count; i++) begin
            issue(ctrl_load, 32'h0000_1a00 + (i << 5), '0, '0, amo_idle, 1'b0);
        end
        drain();
        test_name = "random_burst";
        fetch_before = fetch_count;
        for (int i = 0; i < 48; i++) begin
            addr = 32'h0000_1a00 + (rand_bits(3) << 5) + (rand_bits(2) << 3);
            if (rand_bits(1) == 1) begin
                issue(ctrl_store, addr, rand_bits(64), rand_bits(8), amo_idle, 1'b0);
            end else begin
                issue(ctrl_load, addr, '0, '0, amo_idle, 1'b0);
            end
        end
        drain();
        if (fetch_count != fetch_before) fail_now("a resident line missed during the burst");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
cache_geom_pkg.sv
mem_op_pkg.sv
dcache_ram.sv
dcache_flag_ram.sv
dcache_amo_unit.sv
dcache_req_pipe.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock_gen.sv
tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - cache_geom_pkg.sv
  - mem_op_pkg.sv
  - dcache_ram.sv
  - dcache_flag_ram.sv
  - dcache_amo_unit.sv
  - dcache_req_pipe.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_dcache.sv
